/* Bender.yml */
package:
  name: osd

sources:
  - logic/osd_geom_pkg.sv
  - logic/osd_cmd_pkg.sv
  - logic/osd_spi_rx.sv
  - logic/osd_buffer.sv
  - logic/sync_analyzer.sv
  - logic/osd_window.sv
  - logic/osd_mixer.sv
  - logic/osd_top.sv
  - target: test
    files:
      - test/osd_sva.sv
      - test/tb_osd_top.sv

/* logic/osd_buffer.sv */
`timescale 1ns/1ps

module osd_buffer
	import osd_cmd_pkg::*;
(
	input  logic                  pclk,
	input  logic                  wr_en,
	input  logic [buf_addr_w-1:0] wr_addr,
	input  logic [byte_w-1:0]     wr_data,
	input  logic [buf_addr_w-1:0] rd_addr,
	output logic [byte_w-1:0]     rd_data
);

	// one bit per overlay pixel, 8 vertical pixels per byte
	logic [byte_w-1:0] mem [0:(1 << buf_addr_w) - 1];

	// write port from the serial receiver
	always_ff @(posedge pclk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read port for the video side, one cycle latency
	always_ff @(posedge pclk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* logic/osd_cmd_pkg.sv */
package osd_cmd_pkg;

	// serial frame layout
	localparam int byte_w    = 8;
	localparam int bit_cnt_w = 3;
	// opcode lives in the top five bits of the command byte
	localparam int op_w      = 5;
	// low command bits select one 256 byte block
	localparam int blk_w     = 3;

	// overlay memory is 2 KiB
	localparam int buf_addr_w = 11;

	// opcode field of the command byte
	typedef enum logic [op_w-1:0] {
		cmd_write  = 5'b00100,
		// lowest opcode bit is a don't care here, command bit 0 is on/off
		cmd_enable = 5'b01000
	} osd_cmd_e;

	// receiver position within a frame
	typedef enum logic {
		rx_cmd,
		rx_data
	} rx_state_e;

endpackage

/* logic/osd_geom_pkg.sv */
package osd_geom_pkg;

	// ******************************
	// video side widths
	// ******************************

	// bits per colour channel on the video bus
	localparam int chan_w = 6;

	// pixel counter, wide enough for any line length seen
	localparam int h_cnt_w = 10;
	// line counter within a frame
	localparam int v_cnt_w = 11;

	// ******************************
	// overlay window geometry
	// ******************************

	localparam int osd_width  = 256;
	localparam int osd_height = 128;

	// shift of the window away from the centre of the active area
	localparam int osd_x_offset = 0;
	localparam int osd_y_offset = 0;

	// tint bits, red green blue from msb
	localparam logic [2:0] osd_color = 3'b101;

endpackage

/* logic/osd_mixer.sv */
`timescale 1ns/1ps

module osd_mixer
	import osd_geom_pkg::*;
	import osd_cmd_pkg::*;
(
	input  logic              osd_enable,
	input  logic              osd_de,
	input  logic [2:0]        row_bit,
	input  logic [byte_w-1:0] rd_data,
	input  logic [chan_w-1:0] red_in,
	input  logic [chan_w-1:0] green_in,
	input  logic [chan_w-1:0] blue_in,
	output logic [chan_w-1:0] red_out,
	output logic [chan_w-1:0] green_out,
	output logic [chan_w-1:0] blue_out
);

	logic pixel;
	logic blend_on;

	// pixel in the two top bits, tint next, dimmed video below
	function automatic logic [chan_w-1:0] blend(
		input logic [chan_w-1:0] chan,
		input logic              tint,
		input logic              pix
	);
		blend = {pix, pix, tint, chan[chan_w-1 -: chan_w-3]};
	endfunction

	// bit of the fetched byte for this line pair
	assign pixel = rd_data[row_bit];

	assign blend_on = osd_enable && osd_de;

	// tint bits go red, green, blue from msb
	assign red_out   = blend_on ? blend(red_in, osd_color[2], pixel) : red_in;
	assign green_out = blend_on ? blend(green_in, osd_color[1], pixel) : green_in;
	assign blue_out  = blend_on ? blend(blue_in, osd_color[0], pixel) : blue_in;

endmodule

/* logic/osd_spi_rx.sv */
`timescale 1ns/1ps

module osd_spi_rx
	import osd_cmd_pkg::*;
(
	input  logic                  pclk,
	input  logic                  ss,
	input  logic                  sck,
	input  logic                  sdi,
	input  logic                  cs,
	output logic                  wr_en,
	output logic [buf_addr_w-1:0] wr_addr,
	output logic [byte_w-1:0]     wr_data,
	output logic                  osd_enable
);

	// two stage synchronisers, serial lines are async to pclk
	logic [1:0] sck_sync;
	logic [1:0] sdi_sync;
	logic [1:0] cs_sync;
	// previous synchronised sck for edge detection
	logic       sck_d;
	logic       sck_rise;

	logic [bit_cnt_w-1:0]  bit_cnt;
	logic [byte_w-1:0]     shift_q;
	logic [byte_w-1:0]     rx_byte;
	logic                  byte_done;
	rx_state_e             state;
	// set when the current frame carries a write command
	logic                  wr_frame;
	logic [buf_addr_w-1:0] addr_cnt;

	// ******************************
	// line synchronisation
	// ******************************

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			sck_sync <= 2'b00;
			sdi_sync <= 2'b00;
			// cs idles high, no frame in progress
			cs_sync  <= 2'b11;
			sck_d    <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], sck};
			sdi_sync <= {sdi_sync[0], sdi};
			cs_sync  <= {cs_sync[0], cs};
			sck_d    <= sck_sync[1];
		end
	end

	assign sck_rise = sck_sync[1] & ~sck_d;

	// byte as it stands once the current bit is shifted in, msb first
	assign rx_byte = {shift_q[byte_w-2:0], sdi_sync[1]};

	// eighth bit of a byte while cs is still low
	assign byte_done = sck_rise && !cs_sync[1] && (bit_cnt == bit_cnt_w'(byte_w - 1));

	// ******************************
	// byte assembly
	// ******************************

	always_ff @(posedge pclk) begin
		if (sck_rise) begin
			shift_q <= rx_byte;
		end
		// payload goes out with the write strobe
		if (byte_done && state == rx_data) begin
			wr_data <= rx_byte;
		end
	end

	// command decode and buffer address
	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			bit_cnt    <= '0;
			state      <= rx_cmd;
			wr_frame   <= 1'b0;
			addr_cnt   <= '0;
			wr_addr    <= '0;
			wr_en      <= 1'b0;
			osd_enable <= 1'b0;
		end else begin
			// strobe lasts one cycle
			wr_en <= 1'b0;
			if (cs_sync[1]) begin
				// frame end or abort, partial byte is dropped
				bit_cnt <= '0;
				state   <= rx_cmd;
			end else if (sck_rise) begin
				// wraps to 0 after the eighth bit
				bit_cnt <= bit_cnt + 1'b1;
				if (byte_done) begin
					case (state)
						rx_cmd: begin
							wr_frame <= (rx_byte[byte_w-1 -: op_w] == cmd_write);
							// block base, low byte of the address starts at 0
							addr_cnt <= {rx_byte[blk_w-1:0], {(buf_addr_w - blk_w){1'b0}}};
							if ({rx_byte[byte_w-1 -: op_w-1], 1'b0} == cmd_enable) begin
								osd_enable <= rx_byte[0];
							end
							state <= rx_data;
						end
						rx_data: begin
							// payload of any other command is ignored
							if (wr_frame) begin
								wr_en    <= 1'b1;
								wr_addr  <= addr_cnt;
								addr_cnt <= addr_cnt + 1'b1;
							end
						end
						default: begin
							state <= rx_cmd;
						end
					endcase
				end
			end
		end
	end

endmodule

/* logic/osd_top.sv */
`timescale 1ns/1ps

module osd_top
	import osd_geom_pkg::*;
	import osd_cmd_pkg::*;
(
	input  logic              pclk,
	input  logic              ss,
	input  logic              sck,
	input  logic              sdi,
	input  logic              cs,
	input  logic [chan_w-1:0] red_in,
	input  logic [chan_w-1:0] green_in,
	input  logic [chan_w-1:0] blue_in,
	input  logic              hs_in,
	input  logic              vs_in,
	output logic [chan_w-1:0] red_out,
	output logic [chan_w-1:0] green_out,
	output logic [chan_w-1:0] blue_out,
	output logic              hs_out,
	output logic              vs_out
);

	// host write path
	logic                  wr_en;
	logic [buf_addr_w-1:0] wr_addr;
	logic [byte_w-1:0]     wr_data;
	logic                  osd_enable;

	// video side
	logic [buf_addr_w-1:0] rd_addr;
	logic [byte_w-1:0]     rd_data;
	logic [h_cnt_w-1:0]    h_cnt;
	logic [h_cnt_w-1:0]    h_disp_len;
	logic                  h_pol;
	logic                  hs_s;
	// one strobe per line, clocks the vertical count
	logic                  h_lead;
	logic [v_cnt_w-1:0]    v_cnt;
	logic [v_cnt_w-1:0]    v_disp_len;
	logic                  v_pol;
	logic                  vs_s;
	logic [2:0]            row_bit;
	logic                  osd_de;

	osd_spi_rx spi_rx (
		.pclk       (pclk),
		.ss         (ss),
		.sck        (sck),
		.sdi        (sdi),
		.cs         (cs),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.osd_enable (osd_enable)
	);

	osd_buffer osd_mem (
		.pclk    (pclk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// pixel count within a line
	sync_analyzer #(.cnt_w(h_cnt_w)) h_sync (
		.pclk      (pclk),
		.ss        (ss),
		.sync_in   (hs_in),
		.count_en  (1'b1),
		.sync_s    (hs_s),
		.lead_edge (h_lead),
		.cnt       (h_cnt),
		.pol       (h_pol),
		.disp_len  (h_disp_len)
	);

	// line count within a frame
	sync_analyzer #(.cnt_w(v_cnt_w)) v_sync (
		.pclk      (pclk),
		.ss        (ss),
		.sync_in   (vs_in),
		.count_en  (h_lead),
		.sync_s    (vs_s),
		.lead_edge (),
		.cnt       (v_cnt),
		.pol       (v_pol),
		.disp_len  (v_disp_len)
	);

	osd_window window (
		.pclk       (pclk),
		.ss         (ss),
		.h_cnt      (h_cnt),
		.h_disp_len (h_disp_len),
		.h_pol      (h_pol),
		.hs_s       (hs_s),
		.v_cnt      (v_cnt),
		.v_disp_len (v_disp_len),
		.v_pol      (v_pol),
		.vs_s       (vs_s),
		.rd_addr    (rd_addr),
		.row_bit    (row_bit),
		.osd_de     (osd_de)
	);

	osd_mixer mixer (
		.osd_enable (osd_enable),
		.osd_de     (osd_de),
		.row_bit    (row_bit),
		.rd_data    (rd_data),
		.red_in     (red_in),
		.green_in   (green_in),
		.blue_in    (blue_in),
		.red_out    (red_out),
		.green_out  (green_out),
		.blue_out   (blue_out)
	);

	// syncs go to the connector untouched
	assign hs_out = hs_in;
	assign vs_out = vs_in;

endmodule

/* logic/osd_window.sv */
`timescale 1ns/1ps

module osd_window
	import osd_geom_pkg::*;
	import osd_cmd_pkg::*;
(
	input  logic                  pclk,
	input  logic                  ss,
	input  logic [h_cnt_w-1:0]    h_cnt,
	input  logic [h_cnt_w-1:0]    h_disp_len,
	input  logic                  h_pol,
	input  logic                  hs_s,
	input  logic [v_cnt_w-1:0]    v_cnt,
	input  logic [v_cnt_w-1:0]    v_disp_len,
	input  logic                  v_pol,
	input  logic                  vs_s,
	output logic [buf_addr_w-1:0] rd_addr,
	output logic [2:0]            row_bit,
	output logic                  osd_de
);

	localparam int col_w = $clog2(osd_width);
	localparam int row_w = $clog2(osd_height);

	logic [h_cnt_w-1:0] h_start;
	logic [h_cnt_w-1:0] h_end;
	logic [v_cnt_w-1:0] v_start;
	logic [v_cnt_w-1:0] v_end;
	logic               h_disp;
	logic               v_disp;
	logic               h_active;
	logic               v_active;
	logic               h_act_d;
	logic               v_act_d;
	logic [col_w-1:0]   col_nxt;
	logic [row_w-1:0]   row;

	// ******************************
	// window placement
	// ******************************

	// centre of the display phase, minus half the window
	assign h_start = h_cnt_w'((h_disp_len >> 1) + osd_x_offset - osd_width / 2);
	assign h_end   = h_start + h_cnt_w'(osd_width - 1);
	assign v_start = v_cnt_w'((v_disp_len >> 1) + osd_y_offset - osd_height / 2);
	assign v_end   = v_start + v_cnt_w'(osd_height - 1);

	// line level differs from the sync polarity outside the pulse
	assign h_disp = hs_s != h_pol;
	assign v_disp = vs_s != v_pol;

	// next flag values, flags hold through the sync phase
	always_comb begin
		h_act_d = h_active;
		v_act_d = v_active;
		if (h_disp) begin
			// h_cnt runs every cycle here, so set one pixel early
			if (h_cnt + 1'b1 == h_start) begin
				h_act_d = 1'b1;
			end
			if (h_cnt == h_end) begin
				h_act_d = 1'b0;
			end
		end
		if (v_disp) begin
			// rows change only at the hsync edge, outside the window
			if (v_cnt == v_start) begin
				v_act_d = 1'b1;
			end
			if (v_cnt == v_end + 1'b1) begin
				v_act_d = 1'b0;
			end
		end
	end

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			h_active <= 1'b0;
			v_active <= 1'b0;
			osd_de   <= 1'b0;
		end else begin
			h_active <= h_act_d;
			v_active <= v_act_d;
			osd_de   <= h_act_d && v_act_d;
		end
	end

	// ******************************
	// buffer addressing
	// ******************************

	// fetch one column ahead to cover the read latency
	assign col_nxt = col_w'(h_cnt - h_start + 1'b1);
	assign row     = row_w'(v_cnt - v_start);

	// each byte covers 16 lines, its block picks the upper row bits
	assign rd_addr = {row[row_w-1 -: blk_w], col_nxt};
	// one bit per line pair
	assign row_bit = row[3:1];

endmodule

/* logic/sync_analyzer.sv */
`timescale 1ns/1ps

module sync_analyzer #(
	parameter int cnt_w = 10
) (
	input  logic             pclk,
	input  logic             ss,
	input  logic             sync_in,
	input  logic             count_en,
	output logic             sync_s,
	output logic             lead_edge,
	output logic [cnt_w-1:0] cnt,
	output logic             pol,
	output logic [cnt_w-1:0] disp_len
);

	logic [1:0]       sync_q;
	// one more stage to see the change
	logic             sync_d;
	logic             trail_edge;
	// last measured phase lengths
	logic [cnt_w-1:0] high_len;
	logic [cnt_w-1:0] low_len;

	// ******************************
	// synchroniser and edges
	// ******************************

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			sync_q <= 2'b00;
			sync_d <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], sync_in};
			sync_d <= sync_q[1];
		end
	end

	assign sync_s     = sync_q[1];
	assign lead_edge  = sync_q[1] & ~sync_d;
	assign trail_edge = ~sync_q[1] & sync_d;

	// ******************************
	// phase measurement
	// ******************************

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
		end else if (lead_edge) begin
			// low phase just ended
			cnt     <= '0;
			low_len <= cnt;
		end else if (trail_edge) begin
			// high phase just ended
			cnt      <= '0;
			high_len <= cnt;
		end else if (count_en) begin
			cnt <= cnt + 1'b1;
		end
	end

	// short high phase means the pulse is high, active high sync
	assign pol = high_len < low_len;

	// display phase is the longer one
	assign disp_len = pol ? low_len : high_len;

endmodule

/* test/osd_sva.sv */
`timescale 1ns/1ps

module osd_sva
	import osd_cmd_pkg::*;
(
	input logic                  pclk,
	input logic                  ss,
	input logic                  cs,
	input logic                  wr_en,
	input logic [buf_addr_w-1:0] wr_addr,
	input logic                  osd_de,
	input logic                  hs_s,
	input logic                  h_pol,
	input logic                  vs_s,
	input logic                  v_pol
);

	logic [buf_addr_w-1:0] last_addr;
	// a write has been seen in the current serial frame
	logic                  addr_valid;

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			last_addr  <= '0;
			addr_valid <= 1'b0;
		end else if (cs) begin
			addr_valid <= 1'b0;
		end else if (wr_en) begin
			last_addr  <= wr_addr;
			addr_valid <= 1'b1;
		end
	end

	// ******************************
	// properties
	// ******************************

	assert property (@(posedge pclk) disable iff (ss) wr_en |=> !wr_en)
		else $error("wr_en stayed high for more than one cycle");

	assert property (@(posedge pclk) disable iff (ss)
		osd_de |-> (hs_s != h_pol) && (vs_s != v_pol))
		else $error("osd_de high during a sync pulse");

	assert property (@(posedge pclk) disable iff (ss)
		(wr_en && addr_valid) |-> wr_addr == last_addr + 1'b1)
		else $error("wr_addr did not step by one within a frame");

endmodule

// receiver and window signals meet in the top level
bind osd_top osd_sva sva_i (
	.pclk    (pclk),
	.ss      (ss),
	.cs      (cs),
	.wr_en   (wr_en),
	.wr_addr (wr_addr),
	.osd_de  (osd_de),
	.hs_s    (hs_s),
	.h_pol   (h_pol),
	.vs_s    (vs_s),
	.v_pol   (v_pol)
);

/* test/tb_osd_top.sv */
`timescale 1ns/1ps

module tb_osd_top
	import osd_geom_pkg::*;
();

	// pclk cycles from sync edge to counter restart
	localparam int sync_lat    = 3;
	localparam int line_len    = 400;
	localparam int frame_lines = 200;
	localparam int hsw         = 40;
	localparam int vsw         = 4;
	localparam int frame_cyc   = line_len * frame_lines;
	localparam int n_tests     = 6;
	// three frames per test with 20 % margin
	localparam int cyc_limit   = n_tests * 3 * frame_cyc * 12 / 10;
	localparam int sck_half    = 4;

	typedef logic [7:0] byte_q_t [$];

	logic              pclk;
	logic              ss;
	logic              sck;
	logic              sdi;
	logic              cs;
	logic [chan_w-1:0] red_in;
	logic [chan_w-1:0] green_in;
	logic [chan_w-1:0] blue_in;
	logic              hs_in;
	logic              vs_in;
	logic [chan_w-1:0] red_out;
	logic [chan_w-1:0] green_out;
	logic [chan_w-1:0] blue_out;
	logic              hs_out;
	logic              vs_out;

	// expected buffer contents and overlay state
	logic [7:0]  shadow [0:2047];
	logic        exp_en;
	// requested sync polarity and the one in force for this frame
	logic        inv;
	logic        frame_inv;
	int          frame_cnt;
	int          cur_x;
	int          cur_y;
	logic [31:0] lcg_state;
	int          cyc = 0;

	osd_top UUT (
		.pclk      (pclk),
		.ss        (ss),
		.sck       (sck),
		.sdi       (sdi),
		.cs        (cs),
		.red_in    (red_in),
		.green_in  (green_in),
		.blue_in   (blue_in),
		.hs_in     (hs_in),
		.vs_in     (vs_in),
		.red_out   (red_out),
		.green_out (green_out),
		.blue_out  (blue_out),
		.hs_out    (hs_out),
		.vs_out    (vs_out)
	);

	initial begin
		pclk = 1'b0;
		forever #2 pclk = ~pclk;
	end

	// ******************************
	// helpers
	// ******************************

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// overlay pixel on top, tint, then upper half of the video
	function automatic logic [chan_w-1:0] mix_expect(
		input logic [chan_w-1:0] c,
		input logic              t,
		input logic              p
	);
		return {p, p, t, c[chan_w-1 -: 3]};
	endfunction

	task automatic stop_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_value(input string name, input int expv, input int actv);
		$display("ERR time=%0t %s expected=%0h actual=%0h", $time, name, expv, actv);
		stop_run();
	endtask

	always @(posedge pclk) begin
		cyc <= cyc + 1;
		if (cyc >= cyc_limit) begin
			$display("timeout: the tests did not finish within %0d cycles", cyc_limit);
			stop_run();
		end
	end

	// ******************************
	// video and serial models
	// ******************************

	task automatic run_video();
		logic [31:0] rnd;
		forever begin
			for (int y = 0; y < frame_lines; y++) begin
				for (int x = 0; x < line_len; x++) begin
					@(posedge pclk);
					// polarity only changes on a frame boundary
					if (x == 0 && y == 0) begin
						frame_inv = inv;
						frame_cnt++;
					end
					rnd = lcg_next();
					hs_in    <= (x < hsw) ^ frame_inv;
					vs_in    <= (y < vsw) ^ frame_inv;
					red_in   <= rnd[29:24];
					green_in <= rnd[21:16];
					blue_in  <= rnd[13:8];
					cur_x = x;
					cur_y = y;
				end
			end
		end
	endtask

	// msb first and n_bits may stop inside a byte
	task automatic send_frame(input byte_q_t data, input int n_bits);
		logic [7:0] cur;
		@(posedge pclk);
		cs <= 1'b0;
		repeat (sck_half) @(posedge pclk);
		for (int b = 0; b < n_bits; b++) begin
			cur = data[b / 8];
			sdi <= cur[7 - b % 8];
			sck <= 1'b0;
			repeat (sck_half) @(posedge pclk);
			sck <= 1'b1;
			repeat (sck_half) @(posedge pclk);
		end
		sck <= 1'b0;
		repeat (sck_half) @(posedge pclk);
		cs <= 1'b1;
		repeat (2 * sck_half) @(posedge pclk);
	endtask

	task automatic write_block(input int blk, input int n);
		byte_q_t     data;
		logic [31:0] rnd;
		data.push_back({5'b00100, 3'(blk)});
		for (int i = 0; i < n; i++) begin
			rnd = lcg_next();
			data.push_back(rnd[23:16]);
			shadow[blk * 256 + i] = rnd[23:16];
		end
		send_frame(data, data.size() * 8);
	endtask

	task automatic set_enable(input logic on);
		byte_q_t data;
		data.push_back({4'b0100, 3'b000, on});
		send_frame(data, 8);
		exp_en = on;
	endtask

	// ******************************
	// pixel checks
	// ******************************

	task automatic check_pixel();
		int                v_adj;
		int                h_len;
		int                v_len;
		int                h_start;
		int                v_start;
		int                col;
		int                row;
		logic              pix;
		logic [chan_w-1:0] er;
		logic [chan_w-1:0] eg;
		logic [chan_w-1:0] eb;
		// line strobe follows the vsync restart when hsync is inverted
		v_adj   = frame_inv ? 1 : 0;
		// measured lengths end one below the phase length
		h_len   = line_len - hsw - 1;
		v_len   = frame_lines - vsw - 1 + v_adj;
		h_start = h_len / 2 + osd_x_offset - osd_width / 2;
		v_start = v_len / 2 + osd_y_offset - osd_height / 2;
		col     = cur_x - hsw - sync_lat - h_start;
		row     = cur_y - vsw + v_adj - v_start;
		er = red_in;
		eg = green_in;
		eb = blue_in;
		if (exp_en && col >= 0 && col < osd_width && row >= 0 && row < osd_height) begin
			pix = shadow[(row / 16) * 256 + col][(row / 2) % 8];
			er  = mix_expect(red_in, osd_color[2], pix);
			eg  = mix_expect(green_in, osd_color[1], pix);
			eb  = mix_expect(blue_in, osd_color[0], pix);
		end
		assert (hs_out == hs_in) else report_value("hs_out", hs_in, hs_out);
		assert (vs_out == vs_in) else report_value("vs_out", vs_in, vs_out);
		assert (red_out == er) else report_value("red_out", er, red_out);
		assert (green_out == eg) else report_value("green_out", eg, green_out);
		assert (blue_out == eb) else report_value("blue_out", eb, blue_out);
	endtask

	task automatic check_frames(input int n);
		repeat (n * frame_cyc) begin
			check_pixel();
			@(negedge pclk);
		end
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frame_cnt + n;
		while (frame_cnt < target) @(negedge pclk);
	endtask

	// ******************************
	// directed tests
	// ******************************

	task automatic idle_passthrough();
		wait_frames(1);
		check_frames(2);
	endtask

	task automatic full_overlay();
		for (int blk = 0; blk < 8; blk++) begin
			write_block(blk, 256);
		end
		set_enable(1'b1);
		wait_frames(1);
		check_frames(1);
	endtask

	task automatic disable_reenable();
		set_enable(1'b0);
		wait_frames(1);
		check_frames(1);
		// buffer must still hold the pattern
		set_enable(1'b1);
		wait_frames(1);
		check_frames(1);
	endtask

	task automatic inverted_sync();
		inv = 1'b1;
		// one frame to measure the new phases
		wait_frames(2);
		check_frames(1);
	endtask

	task automatic partial_block_update();
		write_block(5, 16);
		wait_frames(1);
		check_frames(1);
	endtask

	task automatic cut_frame_restart();
		byte_q_t data;
		data.push_back({5'b00100, 3'd6});
		data.push_back(8'ha5);
		// command plus half a payload byte
		send_frame(data, 12);
		write_block(2, 2);
		wait_frames(1);
		check_frames(1);
	endtask

	initial begin
		ss        = 1'b1;
		sck       = 1'b0;
		sdi       = 1'b0;
		cs        = 1'b1;
		red_in    = '0;
		green_in  = '0;
		blue_in   = '0;
		hs_in     = 1'b0;
		vs_in     = 1'b0;
		inv       = 1'b0;
		frame_inv = 1'b0;
		exp_en    = 1'b0;
		frame_cnt = 0;
		lcg_state = 32'd34723;
		repeat (16) @(posedge pclk);
		ss <= 1'b0;
		fork
			run_video();
		join_none
		idle_passthrough();
		full_overlay();
		disable_reenable();
		// later tests keep the inverted syncs
		inverted_sync();
		partial_block_update();
		cut_frame_restart();
		$display("Test OK");
		$finish;
	end

endmodule

/* verilog.f */
logic/osd_geom_pkg.sv
logic/osd_cmd_pkg.sv
logic/osd_spi_rx.sv
logic/osd_buffer.sv
logic/sync_analyzer.sv
logic/osd_window.sv
logic/osd_mixer.sv
logic/osd_top.sv
test/osd_sva.sv
test/tb_osd_top.sv
